//--- sim.f
hw/rs_pkg.sv
hw/lowest_first_pick.sv
hw/rs_control.sv
hw/operand_slot_array.sv
hw/dispatch_stage.sv
hw/rs_mul_top.sv
test/tb_clock_gen.sv
test/rs_mul_tb.sv

//--- Makefile
# Verilator simulation of the multiply reservation station

VERILATOR ?= verilator
TOP       ?= rs_mul_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/rs_mul_tb.sv
`timescale 1ns/1ps

module rs_mul_tb;

    import rs_pkg::*;

    localparam int DEPTH = 16;
    localparam int NB    = 4;

    logic          clk, reset, issue_valid, full, dispatch_valid;
    logic          issue_src1_ready, issue_src2_ready;
    logic [NB-1:0] bcast_valid;
    pc_t           issue_pc, dispatch_pc, exp_pc;
    tag_t          issue_rd, issue_src1_tag, issue_src2_tag, dispatch_rd, exp_rd;
    data_t         issue_src1_data, issue_src2_data, dispatch_src1, dispatch_src2;
    tag_t          bcast_tag [NB];
    data_t         bcast_data [NB];

    // station model with operand index 0 as src1
    logic  m_occ [DEPTH];
    pc_t   m_pc [DEPTH];
    tag_t  m_rd [DEPTH];
    tag_t  m_tag [2][DEPTH];
    data_t m_val [2][DEPTH];
    logic  m_rdy [2][DEPTH];
    logic  exp_valid, exp_full;
    data_t exp_src1, exp_src2;
    int    errors, issued, dispatched, start;

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    rs_mul_top #(.DEPTH(DEPTH), .NUM_BCAST(NB)) UUT (.*);

    function automatic logic bus_hit(input tag_t tag, output data_t data);
        data = '0;
        for (int b = 0; b < NB; b++) begin
            if (bcast_valid[b] && bcast_tag[b] == tag) begin
                data = bcast_data[b];
                return 1'b1;  // lowest bus wins
            end
        end
        return 1'b0;
    endfunction

    function automatic tag_t pool_tag(input int unsigned k);
        return tag_t'(8'h10 + k % 8);  // small pool for frequent wakeups
    endfunction

    // one clock edge of the model using the inputs the DUT samples
    task automatic model_step();
        int    d;
        int    a;
        data_t v;
        d = -1;
        a = -1;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (m_occ[i] && m_rdy[0][i] && m_rdy[1][i])
                d = i;
            if (!m_occ[i])
                a = i;
        end
        exp_valid = (d >= 0);
        if (d >= 0) begin
            exp_pc   = m_pc[d];
            exp_rd   = m_rd[d];
            exp_src1 = m_val[0][d];
            exp_src2 = m_val[1][d];
            m_occ[d] = 1'b0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                if (!m_rdy[s][i] && bus_hit(m_tag[s][i], v)) begin
                    m_val[s][i] = v;
                    m_rdy[s][i] = 1'b1;
                end
            end
        end
        if (issue_valid && a >= 0) begin
            m_occ[a]    = 1'b1;
            m_pc[a]     = issue_pc;
            m_rd[a]     = issue_rd;
            m_tag[0][a] = issue_src1_tag;
            m_val[0][a] = issue_src1_data;
            m_rdy[0][a] = issue_src1_ready;
            m_tag[1][a] = issue_src2_tag;
            m_val[1][a] = issue_src2_data;
            m_rdy[1][a] = issue_src2_ready;
            for (int s = 0; s < 2; s++) begin
                if (!m_rdy[s][a] && bus_hit(m_tag[s][a], v)) begin  // bypass
                    m_val[s][a] = v;
                    m_rdy[s][a] = 1'b1;
                end
            end
            issued++;
        end
        exp_full = 1'b1;
        for (int i = 0; i < DEPTH; i++)
            if (!m_occ[i]) exp_full = 1'b0;
    endtask

    task automatic tick();
        @(posedge clk);
        model_step();
        issue_valid <= 1'b0;
        bcast_valid <= '0;
    endtask

    task automatic drive_issue(input pc_t pc, input tag_t rd, input tag_t t1, input data_t d1,
                               input logic r1, input tag_t t2, input data_t d2, input logic r2);
        issue_valid      <= 1'b1;
        issue_pc         <= pc;
        issue_rd         <= rd;
        issue_src1_tag   <= t1;
        issue_src1_data  <= d1;
        issue_src1_ready <= r1;
        issue_src2_tag   <= t2;
        issue_src2_data  <= d2;
        issue_src2_ready <= r2;
    endtask

    task automatic drive_bus(input int b, input tag_t tag, input data_t data, input logic valid);
        bcast_valid[b] <= valid;
        bcast_tag[b]   <= tag;
        bcast_data[b]  <= data;
    endtask

    task automatic wait_dispatch(input pc_t pc, input int limit);
        int n;
        n = 0;
        do begin
            tick();
            @(negedge clk);
            n++;
        end while (dispatch_valid !== 1'b1 && n < limit);
        if (dispatch_valid !== 1'b1) begin
            errors++;
            $display("timeout at %0t waiting for the dispatch of pc %h", $time, pc);
        end else if (dispatch_pc !== pc) begin
            errors++;
            $display("mismatch at %0t: dispatched pc %h, expected %h", $time, dispatch_pc, pc);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (dispatch_valid !== exp_valid || full !== exp_full) begin
                errors++;
                $display("mismatch at %0t: dispatch_valid %b full %b, expected %b %b",
                         $time, dispatch_valid, full, exp_valid, exp_full);
            end else if (exp_valid && (dispatch_pc !== exp_pc || dispatch_rd !== exp_rd ||
                         dispatch_src1 !== exp_src1 || dispatch_src2 !== exp_src2)) begin
                errors++;
                $display("mismatch at %0t: packet %h %h %h %h, expected %h %h %h %h", $time,
                         dispatch_pc, dispatch_rd, dispatch_src1, dispatch_src2,
                         exp_pc, exp_rd, exp_src1, exp_src2);
            end
            if (dispatch_valid === 1'b1)
                dispatched++;
        end
    end

    initial begin
        void'($urandom(97420));
        errors = 0;
        issued = 0;
        dispatched = 0;
        exp_valid = 1'b0;
        exp_full = 1'b0;
        issue_valid = 1'b0;
        issue_pc = '0;
        issue_rd = '0;
        issue_src1_tag = '0;
        issue_src1_data = '0;
        issue_src1_ready = 1'b0;
        issue_src2_tag = '0;
        issue_src2_data = '0;
        issue_src2_ready = 1'b0;
        bcast_valid = '0;
        for (int b = 0; b < NB; b++) begin
            bcast_tag[b] = '0;
            bcast_data[b] = '0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            m_occ[i] = 1'b0;
            m_rdy[0][i] = 1'b0;
            m_rdy[1][i] = 1'b0;
        end
        for (int k = 0; k < 20 && reset !== 1'b0; k++)
            @(negedge clk);
        if (reset !== 1'b0) begin
            errors++;
            $display("reset was never released");
        end
        repeat (5) tick();  // idle cycles with nothing to dispatch
        tick();
        drive_issue(32'h100, 8'h01, 8'h30, 32'haaaa_0001, 1'b1, 8'h31, 32'hbbbb_0001, 1'b1);
        wait_dispatch(32'h100, 10);
        tick();
        drive_issue(32'h200, 8'h02, 8'h20, 32'h0, 1'b0, 8'h21, 32'hbbbb_0002, 1'b1);
        repeat (3) tick();
        drive_bus(1, 8'h20, 32'hdead_0000, 1'b0);  // same tag on a bus that is not valid
        repeat (3) tick();
        drive_bus(2, 8'h20, 32'hcafe_0002, 1'b1);
        wait_dispatch(32'h200, 10);
        tick();
        drive_issue(32'h300, 8'h03, 8'h22, 32'h0, 1'b0, 8'h23, 32'h0, 1'b0);
        drive_bus(1, 8'h22, 32'hcafe_0003, 1'b1);
        drive_bus(3, 8'h23, 32'hcafe_0004, 1'b1);
        wait_dispatch(32'h300, 10);
        for (int k = 0; k < DEPTH; k++) begin
            tick();
            drive_issue(32'h400 + 4 * k, tag_t'(k), 8'h40, 32'h0, 1'b0, 8'h41, k, 1'b1);
        end
        repeat (3) tick();  // station full with every entry waiting on one tag
        drive_bus(0, 8'h40, 32'h1234_5678, 1'b1);
        for (int k = 0; k < DEPTH; k++)
            wait_dispatch(32'h400 + 4 * k, 20);
        for (int n = 0; n < 3000; n++) begin
            tick();
            if (!exp_full && $urandom % 3 != 0)
                drive_issue(pc_t'($urandom), tag_t'($urandom), pool_tag($urandom), $urandom,
                            ($urandom % 2) == 0, pool_tag($urandom), $urandom,
                            ($urandom % 2) == 0);
            start = $urandom % 8;
            for (int b = 0; b < NB; b++)
                if ($urandom % 4 == 0)
                    drive_bus(b, pool_tag(start + b), $urandom, 1'b1);
        end
        for (int k = 0; k < 100 && dispatched != issued; k++) begin
            tick();
            for (int b = 0; b < NB; b++)
                drive_bus(b, pool_tag(k * NB + b), $urandom, 1'b1);
        end
        repeat (4) tick();
        if (dispatched != issued) begin
            errors++;
            $display("dispatch count %0d differs from issue count %0d after the drain",
                     dispatched, issued);
        end
        $display("errors %0d, issued %0d, dispatched %0d", errors, issued, dispatched);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD       = 8.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;  // released on a rising edge
    end

endmodule

//--- hw/rs_mul_top.sv
`timescale 1ns/1ps

module rs_mul_top #(
    parameter int DEPTH     = rs_pkg::DEFAULT_DEPTH,
    parameter int NUM_BCAST = rs_pkg::DEFAULT_NUM_BCAST
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  rs_pkg::pc_t          issue_pc,
    input  rs_pkg::tag_t         issue_rd,
    input  rs_pkg::tag_t         issue_src1_tag,
    input  rs_pkg::data_t        issue_src1_data,
    input  logic                 issue_src1_ready,
    input  rs_pkg::tag_t         issue_src2_tag,
    input  rs_pkg::data_t        issue_src2_data,
    input  logic                 issue_src2_ready,
    input  logic [NUM_BCAST-1:0] bcast_valid,
    input  rs_pkg::tag_t         bcast_tag [NUM_BCAST],
    input  rs_pkg::data_t        bcast_data [NUM_BCAST],
    output logic                 full,
    output logic                 dispatch_valid,
    output rs_pkg::pc_t          dispatch_pc,
    output rs_pkg::tag_t         dispatch_rd,
    output rs_pkg::data_t        dispatch_src1,
    output rs_pkg::data_t        dispatch_src2
);

    import rs_pkg::*;

    logic [DEPTH-1:0] alloc_onehot;
    logic [DEPTH-1:0] dispatch_onehot;
    logic [DEPTH-1:0] src1_ready_vec;
    logic [DEPTH-1:0] src2_ready_vec;
    data_t            src1_sel;
    data_t            src2_sel;

    rs_control #(
        .DEPTH(DEPTH)
    ) control (
        .clk             (clk),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .src1_ready_vec  (src1_ready_vec),
        .src2_ready_vec  (src2_ready_vec),
        .alloc_onehot    (alloc_onehot),
        .dispatch_onehot (dispatch_onehot),
        .full            (full)
    );

    operand_slot_array #(
        .DEPTH     (DEPTH),
        .NUM_BCAST (NUM_BCAST)
    ) src1_slots (
        .clk             (clk),
        .reset           (reset),
        .alloc_onehot    (alloc_onehot),
        .issue_tag       (issue_src1_tag),
        .issue_data      (issue_src1_data),
        .issue_ready     (issue_src1_ready),
        .bcast_valid     (bcast_valid),
        .bcast_tag       (bcast_tag),
        .bcast_data      (bcast_data),
        .dispatch_onehot (dispatch_onehot),
        .ready_vec       (src1_ready_vec),
        .sel_data        (src1_sel)
    );

    operand_slot_array #(
        .DEPTH     (DEPTH),
        .NUM_BCAST (NUM_BCAST)
    ) src2_slots (
        .clk             (clk),
        .reset           (reset),
        .alloc_onehot    (alloc_onehot),
        .issue_tag       (issue_src2_tag),
        .issue_data      (issue_src2_data),
        .issue_ready     (issue_src2_ready),
        .bcast_valid     (bcast_valid),
        .bcast_tag       (bcast_tag),
        .bcast_data      (bcast_data),
        .dispatch_onehot (dispatch_onehot),
        .ready_vec       (src2_ready_vec),
        .sel_data        (src2_sel)
    );

    dispatch_stage #(
        .DEPTH(DEPTH)
    ) dispatch (
        .clk             (clk),
        .reset           (reset),
        .alloc_onehot    (alloc_onehot),
        .issue_pc        (issue_pc),
        .issue_rd        (issue_rd),
        .dispatch_onehot (dispatch_onehot),
        .src1_sel        (src1_sel),
        .src2_sel        (src2_sel),
        .dispatch_valid  (dispatch_valid),
        .dispatch_pc     (dispatch_pc),
        .dispatch_rd     (dispatch_rd),
        .dispatch_src1   (dispatch_src1),
        .dispatch_src2   (dispatch_src2)
    );

endmodule

//--- hw/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage #(
    parameter int DEPTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [DEPTH-1:0] alloc_onehot,
    input  rs_pkg::pc_t      issue_pc,
    input  rs_pkg::tag_t     issue_rd,
    input  logic [DEPTH-1:0] dispatch_onehot,
    input  rs_pkg::data_t    src1_sel,
    input  rs_pkg::data_t    src2_sel,
    output logic             dispatch_valid,
    output rs_pkg::pc_t      dispatch_pc,
    output rs_pkg::tag_t     dispatch_rd,
    output rs_pkg::data_t    dispatch_src1,
    output rs_pkg::data_t    dispatch_src2
);

    import rs_pkg::*;

    pc_t  pc_q [DEPTH];
    tag_t rd_q [DEPTH];
    pc_t  sel_pc;
    tag_t sel_rd;

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (alloc_onehot[i]) begin
                pc_q[i] <= issue_pc;
                rd_q[i] <= issue_rd;
            end
        end
    end

    always_comb begin
        sel_pc = '0;
        sel_rd = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (dispatch_onehot[i]) begin
                sel_pc = sel_pc | pc_q[i];
                sel_rd = sel_rd | rd_q[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= |dispatch_onehot;  // one pulse per packet
        end
    end

    // packet fields only mean something with dispatch_valid
    always_ff @(posedge clk) begin
        dispatch_pc   <= sel_pc;
        dispatch_rd   <= sel_rd;
        dispatch_src1 <= src1_sel;
        dispatch_src2 <= src2_sel;
    end

    valid_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(dispatch_valid)
    ) else $error("dispatch_valid unknown");

endmodule

//--- hw/operand_slot_array.sv
`timescale 1ns/1ps

module operand_slot_array #(
    parameter int DEPTH,
    parameter int NUM_BCAST
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [DEPTH-1:0]     alloc_onehot,
    input  rs_pkg::tag_t         issue_tag,
    input  rs_pkg::data_t        issue_data,
    input  logic                 issue_ready,
    input  logic [NUM_BCAST-1:0] bcast_valid,
    input  rs_pkg::tag_t         bcast_tag [NUM_BCAST],
    input  rs_pkg::data_t        bcast_data [NUM_BCAST],
    input  logic [DEPTH-1:0]     dispatch_onehot,
    output logic [DEPTH-1:0]     ready_vec,
    output rs_pkg::data_t        sel_data
);

    import rs_pkg::*;

    tag_t             tag_q [DEPTH];
    data_t            val_q [DEPTH];
    logic             byp_hit;
    data_t            byp_data;
    logic [DEPTH-1:0] wake_hit;
    data_t            wake_data [DEPTH];

    // scans from the top so the lowest matching bus is kept
    function automatic logic bus_match(input tag_t tag, output data_t data);
        logic hit;
        hit  = 1'b0;
        data = '0;
        for (int b = NUM_BCAST - 1; b >= 0; b--) begin
            if (bcast_valid[b] && bcast_tag[b] == tag) begin
                hit  = 1'b1;
                data = bcast_data[b];
            end
        end
        return hit;
    endfunction

    always_comb begin
        byp_hit = bus_match(issue_tag, byp_data);  // issue-time bypass
        for (int i = 0; i < DEPTH; i++) begin
            wake_hit[i] = bus_match(tag_q[i], wake_data[i]);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready_vec <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (alloc_onehot[i]) begin
                    ready_vec[i] <= issue_ready | byp_hit;
                end else if (wake_hit[i]) begin
                    ready_vec[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (alloc_onehot[i]) begin
                tag_q[i] <= issue_tag;
                val_q[i] <= (issue_ready || !byp_hit) ? issue_data : byp_data;
            end else if (!ready_vec[i] && wake_hit[i]) begin
                val_q[i] <= wake_data[i];  // wakeup, only while waiting
            end
        end
    end

    always_comb begin
        sel_data = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (dispatch_onehot[i]) begin
                sel_data = sel_data | val_q[i];
            end
        end
    end

endmodule

//--- hw/rs_control.sv
`timescale 1ns/1ps

module rs_control #(
    parameter int DEPTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             issue_valid,
    input  logic [DEPTH-1:0] src1_ready_vec,
    input  logic [DEPTH-1:0] src2_ready_vec,
    output logic [DEPTH-1:0] alloc_onehot,
    output logic [DEPTH-1:0] dispatch_onehot,
    output logic             full
);

    logic [DEPTH-1:0] occupied;
    logic [DEPTH-1:0] entry_ready;
    logic [DEPTH-1:0] free_grant;

    // ready bits of empty slots are stale, occupancy masks them
    assign entry_ready = occupied & src1_ready_vec & src2_ready_vec;
    assign full        = &occupied;

    lowest_first_pick #(
        .WIDTH(DEPTH)
    ) free_pick (
        .req   (~occupied),
        .grant (free_grant)
    );

    lowest_first_pick #(
        .WIDTH(DEPTH)
    ) ready_pick (
        .req   (entry_ready),
        .grant (dispatch_onehot)
    );

    // free_grant is zero when full, so a stray issue is dropped
    assign alloc_onehot = issue_valid ? free_grant : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            occupied <= '0;
        end else begin
            occupied <= (occupied & ~dispatch_onehot) | alloc_onehot;  // alloc and dispatch never share a slot
        end
    end

    // issuer must hold off while the station is full
    no_issue_when_full: assert property (
        @(posedge clk) disable iff (reset)
        issue_valid |-> !full
    ) else $error("issue while full");

    single_dispatch: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(dispatch_onehot)
    ) else $error("more than one entry dispatched");

    alloc_into_free: assert property (
        @(posedge clk) disable iff (reset)
        (alloc_onehot & occupied) == '0
    ) else $error("allocation into an occupied slot");

endmodule

//--- hw/lowest_first_pick.sv
`timescale 1ns/1ps

module lowest_first_pick #(
    parameter int WIDTH
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] grant
);

    logic found;  // a lower bit already won

    always_comb begin
        grant = '0;
        found = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            if (req[i] && !found) begin
                grant[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

endmodule

//--- hw/rs_pkg.sv
package rs_pkg;

    // physical register tag, enough for 256 rename registers
    typedef logic [7:0] tag_t;

    // operand and result word
    typedef logic [31:0] data_t;

    typedef logic [31:0] pc_t;  // instruction address

    // station size and number of result buses when the top is not overridden
    localparam int DEFAULT_DEPTH     = 16;
    localparam int DEFAULT_NUM_BCAST = 4;  // alu, mul, div, load

endpackage
